// File: project.f
design/hdc_pkg.sv
design/hdc_seq_pkg.sv
design/hv_item_memory.sv
design/hv_encode_core.sv
design/bundle_counter.sv
design/buffer_ctrl.sv
design/bundle_sequencer.sv
design/hdc_bundler_top.sv
sim/tb_hdc_bundler.sv

// File: Bender.yml
package:
  name: hdc_bundler

sources:
  # packages first
  - design/hdc_pkg.sv
  - design/hdc_seq_pkg.sv
  # leaf modules up to the top level
  - design/hv_item_memory.sv
  - design/hv_encode_core.sv
  - design/bundle_counter.sv
  - design/buffer_ctrl.sv
  - design/bundle_sequencer.sv
  - design/hdc_bundler_top.sv
  # testbench
  - target: test
    files:
      - sim/tb_hdc_bundler.sv

// File: sim/tb_hdc_bundler.sv
`timescale 1ns/1ps

module tb_hdc_bundler;

    import hdc_pkg::*;
    import hdc_seq_pkg::*;

    localparam int sym_bits      = num_cores * sym_w;
    localparam int rand_bundles  = 40;
    localparam int max_rand_len  = 20;
    localparam int max_gap       = 3;
    localparam int single_cycles = 16;
    localparam int b2b_cycles    = 30;
    // reset, reset-state window, every test, then drain margin
    localparam int timeout_cycles = 2 + 4 + single_cycles
        + rand_bundles * (max_rand_len + max_gap) + b2b_cycles + max_bundle_len + 50;

    logic                 clk;
    logic                 reset;
    logic [num_cores-1:0] sample_valid;
    logic [sym_bits-1:0]  sample_symbol;
    logic [pos_w-1:0]     sample_pos;
    logic                 sample_last;
    hv_t                  result_hv;
    logic                 result_valid;
    logic [count_w-1:0]   result_count;

    int          cycle = 0;
    logic [31:0] rng_state;
    // model of the open bundle
    int          votes [hv_dim];
    int          bundle_cycles;
    // expected results, oldest first
    hv_t         exp_hv_q [$];
    int          exp_count_q [$];
    int          exp_due_q [$];

    hdc_bundler_top hdc_bundler_top_i (
        .clk           (clk),
        .reset         (reset),
        .sample_valid  (sample_valid),
        .sample_symbol (sample_symbol),
        .sample_pos    (sample_pos),
        .sample_last   (sample_last),
        .result_hv     (result_hv),
        .result_valid  (result_valid),
        .result_count  (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift_step(rng_state);
        return rng_state;
    endfunction

    // item vector, seeded with index plus one, upper word first
    function automatic hv_t ref_item_vector(input int idx);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = xorshift_step(32'(idx + 1));
        lo = xorshift_step(hi);
        return {hi, lo};
    endfunction

    function automatic hv_t rotate_left(input hv_t v, input int n);
        return (v << n) | (v >> (hv_dim - n));
    endfunction

    // symbol vector rotated by position, bound to the core's channel
    function automatic hv_t encode_sample(input int k, input int sym, input int pos);
        return rotate_left(ref_item_vector(sym), pos) ^ ref_item_vector(num_symbols + k);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic clear_model();
        foreach (votes[i]) begin
            votes[i] = 0;
        end
        bundle_cycles = 0;
    endtask

    // majority per dimension, tie gives 0
    task automatic push_expected();
        hv_t exp_hv;
        for (int i = 0; i < hv_dim; i++) begin
            exp_hv[i] = (votes[i] > 0);
        end
        exp_hv_q.push_back(exp_hv);
        exp_count_q.push_back(bundle_cycles);
        // cores, counters, capture
        exp_due_q.push_back(cycle + 3);
        clear_model();
    endtask

    task automatic present_sample(input logic [num_cores-1:0] mask,
                                  input logic [sym_bits-1:0] syms,
                                  input logic [pos_w-1:0] pos, input bit last);
        hv_t enc;
        @(posedge clk);
        #2;
        sample_valid  = mask;
        sample_symbol = syms;
        sample_pos    = pos;
        sample_last   = last;
        bundle_cycles++;
        for (int k = 0; k < num_cores; k++) begin
            if (mask[k]) begin
                enc = encode_sample(k, syms[k*sym_w +: sym_w], pos);
                for (int i = 0; i < hv_dim; i++) begin
                    votes[i] += enc[i] ? 1 : -1;
                end
            end
        end
        if (last) begin
            push_expected();
        end
    endtask

    // junk on symbol and position while no core is valid
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            sample_valid  = '0;
            sample_last   = 1'b0;
            sample_symbol = sym_bits'(next_rand());
            sample_pos    = pos_w'(next_rand());
        end
    endtask

    task automatic random_bundle(input int len);
        logic [num_cores-1:0] mask;
        for (int s = 0; s < len; s++) begin
            mask = num_cores'(next_rand());
            // every sample cycle needs at least one core
            if (mask == '0) begin
                mask = 1;
            end
            present_sample(mask, sym_bits'(next_rand()), pos_w'(next_rand()), s == len - 1);
        end
    endtask

    // outputs settle well before the falling edge
    task automatic check_outputs();
        if (result_valid === 1'b1) begin
            if (exp_due_q.size() == 0) begin
                abort_run("error: result_valid with no bundle outstanding");
            end
            if (exp_due_q[0] != cycle) begin
                abort_run("error: result_valid not 3 cycles after sample_last");
            end
            assert (result_hv === exp_hv_q[0])
                else report_value("result_hv", result_hv, exp_hv_q[0]);
            assert (result_count === count_w'(exp_count_q[0]))
                else report_value("result_count", 64'(result_count), 64'(exp_count_q[0]));
            void'(exp_hv_q.pop_front());
            void'(exp_count_q.pop_front());
            void'(exp_due_q.pop_front());
        end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle) begin
            abort_run("error: result_valid missing 3 cycles after sample_last");
        end
    endtask

    always @(negedge clk) begin
        if (reset === 1'b0) begin
            check_outputs();
        end
    end

    initial begin
        wait (cycle >= timeout_cycles);
        abort_run("error: run did not finish within the cycle limit");
    end

    initial begin
        int single_lens [4];
        int len;
        single_lens   = '{1, 2, 3, 2};
        reset         = 1'b1;
        sample_valid  = '0;
        sample_symbol = '0;
        sample_pos    = '0;
        sample_last   = 1'b0;
        rng_state     = 32'd20;
        clear_model();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        // reset state, nothing sampled yet
        repeat (4) begin
            @(negedge clk);
            assert (result_valid === 1'b0)
                else abort_run("error: result_valid high before any sample");
            assert (result_hv === '0)
                else report_value("result_hv", result_hv, 64'h0);
        end

        // core 0 only, two-sample bundle hits ties
        foreach (single_lens[b]) begin
            for (int s = 0; s < single_lens[b]; s++) begin
                present_sample(4'b0001, sym_bits'(next_rand()), pos_w'(next_rand()),
                               s == single_lens[b] - 1);
            end
            idle_cycles(2);
        end

        // random masks, positions and gaps, gap 0 runs bundles together
        for (int b = 0; b < rand_bundles; b++) begin
            len = 1 + int'(next_rand() % max_rand_len);
            random_bundle(len);
            idle_cycles(int'(next_rand() % (max_gap + 1)));
        end

        // strictly back to back
        for (int b = 0; b < 5; b++) begin
            random_bundle(b % 4 + 1);
        end
        idle_cycles(2);

        // longest bundle, every core, constant input
        for (int s = 0; s < max_bundle_len; s++) begin
            present_sample(4'hf, 16'h3a5c, 6'd13, s == max_bundle_len - 1);
        end
        idle_cycles(1);

        while (exp_due_q.size() != 0) begin
            @(negedge clk);
        end
        // a stray result_valid shows up here
        idle_cycles(3);
        @(negedge clk);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: design/hdc_bundler_top.sv
`timescale 1ns/1ps

module hdc_bundler_top (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic [hdc_pkg::num_cores-1:0]                   sample_valid,
    input  logic [hdc_pkg::num_cores*hdc_pkg::sym_w-1:0]    sample_symbol,
    input  logic [hdc_pkg::pos_w-1:0]                       sample_pos,
    input  logic                                            sample_last,
    output hdc_pkg::hv_t                                    result_hv,
    output logic                                            result_valid,
    output logic [hdc_seq_pkg::count_w-1:0]                 result_count
);

    import hdc_pkg::*;

    hv_t                  core_result [num_cores];
    logic [num_cores-1:0] store;
    logic                 sample_any;
    logic                 stream_v;
    logic                 clear;

    // any core taking a sample counts as one sample cycle
    assign sample_any = |sample_valid;

    // encoding cores, symbol slice k goes to core k
    for (genvar k = 0; k < num_cores; k++) begin : g_core
        hv_encode_core #(
            .core_id (k)
        ) core (
            .clk    (clk),
            .reset  (reset),
            .valid  (sample_valid[k]),
            .symbol (sample_symbol[k*sym_w +: sym_w]),
            .pos    (sample_pos),
            .result (core_result[k]),
            .store  (store[k])
        );
    end

    // vote bank and result register
    buffer_ctrl buffer (
        .clk           (clk),
        .reset         (reset),
        .core_result_0 (core_result[0]),
        .core_result_1 (core_result[1]),
        .core_result_2 (core_result[2]),
        .core_result_3 (core_result[3]),
        .store         (store),
        .stream_v      (stream_v),
        .clear         (clear),
        .stream_d      (result_hv),
        .sign_bit      ()
    );

    // marker delay, flush pulse and sample count
    bundle_sequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .sample_any   (sample_any),
        .sample_last  (sample_last),
        .stream_v     (stream_v),
        .clear        (clear),
        .result_valid (result_valid),
        .result_count (result_count)
    );

endmodule

// File: design/bundle_sequencer.sv
`timescale 1ns/1ps

module bundle_sequencer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sample_any,
    input  logic                                sample_last,
    output logic                                stream_v,
    output logic                                clear,
    output logic                                result_valid,
    output logic [hdc_seq_pkg::count_w-1:0]     result_count
);

    import hdc_seq_pkg::*;

    seq_state_t         state;
    seq_state_t         state_d;
    logic               last_n;
    logic               last_nn;
    logic [count_w-1:0] count_q;
    logic [count_w-1:0] count_cur;
    logic [count_w-1:0] count_n;
    logic [count_w-1:0] count_nn;
    logic               bundle_open;

    // bundle still collecting samples after this cycle
    always_comb begin
        if (sample_any) begin
            bundle_open = !sample_last;
        end else begin
            bundle_open = (state == accumulating);
        end
    end

    // flushing while a marker sits in the delay line
    always_comb begin
        if (bundle_open) begin
            state_d = accumulating;
        end else if ((sample_any && sample_last) || last_n) begin
            state_d = flushing;
        end else begin
            state_d = idle;
        end
    end

    // first sample of a bundle restarts the count
    assign count_cur = (state == accumulating) ? count_q + count_w'(1) : count_w'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            last_n       <= 1'b0;
            last_nn      <= 1'b0;
            result_valid <= 1'b0;
            count_q      <= '0;
            result_count <= '0;
        end else begin
            state        <= state_d;
            // marker follows the core and counter stages
            last_n       <= sample_any && sample_last;
            last_nn      <= last_n;
            result_valid <= last_nn;
            // sample cycles of the open bundle
            if (sample_any) begin
                count_q <= count_cur;
            end
            // held until the next result
            if (last_nn) begin
                result_count <= count_nn;
            end
        end
    end

    // count rides along with the marker
    always_ff @(posedge clk) begin
        if (sample_any && sample_last) begin
            count_n <= count_cur;
        end
        count_nn <= count_n;
    end

    // capture and restart in one pulse
    assign stream_v = last_nn;
    assign clear    = last_nn;

    a_bundle_len : assert property (
        @(posedge clk) disable iff (reset)
            sample_any && state == accumulating |-> count_q < max_bundle_len
    ) else $error("bundle_sequencer: bundle longer than %0d samples", max_bundle_len);

    a_last_needs_sample : assert property (
        @(posedge clk) disable iff (reset) sample_last |-> sample_any
    ) else $error("bundle_sequencer: last marker without a sample");

endmodule

// File: design/buffer_ctrl.sv
`timescale 1ns/1ps

module buffer_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  hdc_pkg::hv_t                    core_result_0,
    input  hdc_pkg::hv_t                    core_result_1,
    input  hdc_pkg::hv_t                    core_result_2,
    input  hdc_pkg::hv_t                    core_result_3,
    input  logic [hdc_pkg::num_cores-1:0]   store,
    input  logic                            stream_v,
    input  logic                            clear,
    output hdc_pkg::hv_t                    stream_d,
    output hdc_pkg::hv_t                    sign_bit
);

    import hdc_pkg::*;

    // one counter per dimension
    for (genvar i = 0; i < hv_dim; i++) begin : g_dim
        bundle_counter counter (
            .clk         (clk),
            .reset       (reset),
            .clear       (clear),
            .store       (store),
            // core 0 at bit 0, same order as store
            .core_result ({core_result_3[i], core_result_2[i],
                           core_result_1[i], core_result_0[i]}),
            .sign_bit    (sign_bit[i])
        );
    end

    // sign bits are final while stream_v is high
    // captured on the following edge
    always_ff @(posedge clk) begin
        if (reset) begin
            stream_d <= '0;
        end else if (stream_v) begin
            stream_d <= sign_bit;
        end
    end

endmodule

// File: design/bundle_counter.sv
`timescale 1ns/1ps

module bundle_counter (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clear,
    input  logic [hdc_pkg::num_cores-1:0]   store,
    input  logic [hdc_pkg::num_cores-1:0]   core_result,
    output logic                            sign_bit
);

    import hdc_pkg::*;

    localparam logic signed [cnt_w-1:0] plus_one  = 1;
    localparam logic signed [cnt_w-1:0] minus_one = -1;

    logic signed [cnt_w-1:0] cnt_q;
    logic signed [cnt_w-1:0] votes;
    logic signed [cnt_w-1:0] cnt_base;
    logic signed [cnt_w-1:0] cnt_d;
    logic                    wrap;

    // sum of this cycle's votes, idle cores add nothing
    always_comb begin
        votes = '0;
        for (int k = 0; k < num_cores; k++) begin
            if (store[k]) begin
                votes = votes + (core_result[k] ? plus_one : minus_one);
            end
        end
    end

    // clear drops the old bundle but keeps the new votes
    assign cnt_base = clear ? '0 : cnt_q;
    assign cnt_d    = cnt_base + votes;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // strictly positive wins, a tie gives 0
    assign sign_bit = (cnt_q > 0);

    // same-sign operands giving a flipped sign
    assign wrap = (cnt_base[cnt_w-1] == votes[cnt_w-1])
               && (cnt_d[cnt_w-1] != cnt_base[cnt_w-1]);

    a_no_wrap : assert property (
        @(posedge clk) disable iff (reset) !wrap
    ) else $error("bundle_counter: vote counter wrapped");

endmodule

// File: design/hv_encode_core.sv
`timescale 1ns/1ps

module hv_encode_core #(
    parameter int core_id = 0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        valid,
    input  logic [hdc_pkg::sym_w-1:0]   symbol,
    input  logic [hdc_pkg::pos_w-1:0]   pos,
    output hdc_pkg::hv_t                result,
    output logic                        store
);

    import hdc_pkg::*;

    // this core's channel vector, a constant
    localparam hv_t channel_hv = item_hv(num_symbols + core_id);

    hv_t               sym_hv;
    hv_t               rot_hv;
    logic [2*hv_dim-1:0] rot_wide;

    // symbol table starts at item 0
    hv_item_memory #(
        .base  (0),
        .depth (num_symbols)
    ) sym_mem (
        .clk (clk),
        .idx (symbol),
        .hv  (sym_hv)
    );

    // rotate left by pos
    // doubled copy so the wrapped bits fall into the upper half
    always_comb begin
        rot_wide = {sym_hv, sym_hv} << pos;
        rot_hv   = rot_wide[2*hv_dim-1:hv_dim];
    end

    // store strobe, control state
    always_ff @(posedge clk) begin
        if (reset) begin
            store <= 1'b0;
        end else begin
            store <= valid;
        end
    end

    // bound vector, only updated for a real sample
    always_ff @(posedge clk) begin
        if (valid) begin
            result <= rot_hv ^ channel_hv;
        end
    end

endmodule

// File: design/hv_item_memory.sv
`timescale 1ns/1ps

module hv_item_memory #(
    parameter int base  = 0,
    parameter int depth = 16,
    parameter int idx_w = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic             clk,
    input  logic [idx_w-1:0] idx,
    output hdc_pkg::hv_t     hv
);

    import hdc_pkg::*;

    // constant table, filled at elaboration
    hv_t rom [depth];

    for (genvar i = 0; i < depth; i++) begin : g_entry
        localparam hv_t entry = item_hv(base + i);
        assign rom[i] = entry;
    end

    // plain lookup, no register
    assign hv = rom[idx];

    // index stays inside the table
    // unknown index between samples is not a lookup
    a_idx_range : assert property (
        @(posedge clk) !$isunknown(idx) |-> idx < depth
    ) else $error("hv_item_memory: index %0d outside table of %0d", idx, depth);

endmodule

// File: design/hdc_seq_pkg.sv
package hdc_seq_pkg;

    // bundle sequencer states
    typedef enum logic [1:0] {
        idle,
        accumulating,
        flushing
    } seq_state_t;

    // sample cycles allowed in one bundle
    localparam int max_bundle_len = 255;
    // width of the sample count
    localparam int count_w        = 8;

endpackage

// File: design/hdc_pkg.sv
package hdc_pkg;

    // hypervector geometry
    localparam int hv_dim      = 64;
    localparam int num_cores   = 4;
    localparam int num_symbols = 16;
    localparam int sym_w       = 4;
    localparam int pos_w       = 6;
    // signed vote counter, wide enough for the longest bundle
    localparam int cnt_w       = 12;

    typedef logic [hv_dim-1:0] hv_t;

    // fixed pseudo-random vector per item
    // items 0..15 are symbols, 16..19 the channel vectors of cores 0..3
    function automatic hv_t item_hv(input int unsigned idx);
        logic [31:0] x;
        logic [31:0] word [2];
        x = 32'(idx + 1);
        // two xorshift32 steps, first one lands in the upper half
        for (int s = 0; s < 2; s++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            word[s] = x;
        end
        return {word[0], word[1]};
    endfunction

endpackage
